//--- tests/ac97_vectors.txt
// columns: op addr data/mask expect, hex; 1 test, 2 write, 3 masked read, 4 poll bits
// 5 push pairs, 6 tick and check line out, 7 record fill, 8 record pairs, 9 ticks, a/b irq
1 0 1 0
4 8 20 0
3 8 ff 28
1 0 2 0
2 18 beef 0
2 10 0a 0
2 10 8a 0
4 8 10 0
3 14 ffff beef
2 18 1230 0
2 10 26 0
2 10 a6 0
4 8 10 0
3 14 ffff 123f
1 0 3 0
9 0 1 0
2 c 1 0
3 8 40 0
5 0 7 0
b 0 1 0
5 0 1 0
a 0 0 0
6 0 8 0
3 8 40 0
6 0 1 0
3 8 40 40
1 0 4 0
9 0 1 0
2 c 2 0
7 0 7 0
b 1 0 0
7 0 1 0
a 1 1 0
8 0 8 0
7 0 f 0
3 8 04 04
3 8 80 0
9 0 1 0
3 8 80 80
1 0 5 0
9 0 1 0
2 0 1111 0
3 4 0 0
3 8 c0 c0
2 c 3 0
3 8 cb 08
5 0 1 0
6 0 1 0
8 0 1 0
0 0 0 0

//--- ac97_ctrl.f
source/ac97_bus_pkg.sv
source/ac97_audio_pkg.sv
source/ac97_sample_tick.sv
source/ac97_sample_fifo.sv
source/ac97_fifo_monitor.sv
source/ac97_codec_regs.sv
source/ac97_bus_regs.sv
source/ac97_ctrl_top.sv
tests/ac97_checker.sv
tests/tb_ac97_ctrl.sv

//--- Bender.yml
package:
  name: ac97_ctrl

sources:
  - source/ac97_bus_pkg.sv
  - source/ac97_audio_pkg.sv
  - source/ac97_sample_tick.sv
  - source/ac97_sample_fifo.sv
  - source/ac97_fifo_monitor.sv
  - source/ac97_codec_regs.sv
  - source/ac97_bus_regs.sv
  - source/ac97_ctrl_top.sv
  - target: test
    files:
      - tests/ac97_checker.sv
      - tests/tb_ac97_ctrl.sv

//--- tests/tb_ac97_ctrl.sv
/*
  testbench for the AC97 controller, stimulus from tests/ac97_vectors.txt
  vector columns: op, address, data or mask, expected value, all hex
  audio pairs are random, a queue model of both FIFOs gives their expected values
  simulation is about one millisecond because ticks come every 2604 cycles
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ac97_ctrl;

  import ac97_bus_pkg::*;
  import ac97_audio_pkg::*;

  localparam int ack_limit  = 4;     // cycles to ack
  localparam int tick_limit = 3000;  // one tick period plus margin
  localparam int poll_limit = 64;    // status reads per poll
  localparam int irq_limit  = 64;

  logic        clk_adc_125mhz;
  logic        adc_rstn_i;
  bus_req_t    sys_req;
  bus_rsp_t    sys_rsp;
  stereo_t     line_in;
  stereo_t     line_out;
  logic        irq_play;
  logic        irq_rec;
  logic [31:0] vec [256];  // four words per vector
  int          seed;
  int          idx;
  bit          aborted;    // a wait ran out
  stereo_t     play_q[$];  // model of the play FIFO
  stereo_t     rec_q[$];   // model of the record FIFO
  stereo_t     last_out;   // pair line_out should hold
  sample_t     play_left;
  bit          play_half;  // next play write is right
  bit          rec_half;   // next record read is right

  ac97_ctrl_top #(
    .fifo_depth(16), .tick_div(2604), .tick_frac(5),
    .play_irq_level(irq_half_empty), .rec_irq_level(irq_half_full)
  ) u_dut (
    .clk_adc_125mhz, .adc_rstn_i, .sys_req_i(sys_req), .sys_rsp_o(sys_rsp),
    .line_in_i(line_in), .line_out_o(line_out), .irq_play_o(irq_play), .irq_rec_o(irq_rec)
  );

  ac97_checker u_checker (
    .clk_adc_125mhz, .rsp_i(sys_rsp), .line_out_i(line_out),
    .irq_play_i(irq_play), .irq_rec_i(irq_rec)
  );

  initial begin
    clk_adc_125mhz = 1'b0;
    forever #4 clk_adc_125mhz = ~clk_adc_125mhz;  // 125 MHz
  end

  // ----------------------------------------
  // tick drains play into line out and fills record from line in
  always @(posedge clk_adc_125mhz) begin
    if (adc_rstn_i && u_dut.tick) begin
      if (play_q.size() > 0) last_out = play_q.pop_front();
      if (rec_q.size() < 16) rec_q.push_back(line_in);  // full FIFO drops the sample
    end
  end

  task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] wdata,
                           input bit write, output logic [31:0] data);
    int n;
    @(posedge clk_adc_125mhz);
    #1;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = write;
    sys_req.ren   = !write;
    @(posedge clk_adc_125mhz);
    #1;
    sys_req.wen = 1'b0;  // single cycle strobe
    sys_req.ren = 1'b0;
    n = 0;
    do begin
      @(negedge clk_adc_125mhz);
      n++;
    end while (!sys_rsp.ack && n < ack_limit);
    data = sys_rsp.rdata;
    if (!sys_rsp.ack) begin
      $display("timeout: no bus acknowledge for address %h", addr);
      aborted = 1'b1;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] ignored_rdata;
    bus_cycle(addr, data, 1'b1, ignored_rdata);
    if (addr[19:0] == play_fifo) begin
      if (play_half && play_q.size() < 16) play_q.push_back('{right: data[15:0], left: play_left});
      if (!play_half) play_left = data[15:0];
      play_half = !play_half;
    end
    if (addr[19:0] == fifo_reset) begin
      if (data[0]) begin
        play_q.delete();
        play_half = 1'b0;
      end
      if (data[1]) begin
        rec_q.delete();
        rec_half = 1'b0;
      end
    end
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    stereo_t dropped;
    bus_cycle(addr, 32'h0, 1'b0, data);
    if (addr[19:0] == rec_fifo) begin
      if (rec_half && rec_q.size() > 0) dropped = rec_q.pop_front();  // right half pops
      rec_half = !rec_half;
    end
  endtask

  // one record half, expected from the queue model
  task automatic check_rec_half();
    logic [31:0] rdata;
    logic [15:0] half;
    half = rec_half ? rec_q[0].right : rec_q[0].left;
    read_reg(rec_fifo, rdata);
    if (!aborted) u_checker.compare_read(rec_fifo, 32'hFFFF, {16'h0, half});
  endtask

  task automatic poll_reg(input logic [31:0] addr, input logic [31:0] mask);
    logic [31:0] data;
    int          n;
    n = 0;
    do begin
      read_reg(addr, data);
      n++;
    end while (!aborted && (data & mask) == 0 && n < poll_limit);
    if (!aborted && (data & mask) == 0) begin
      $display("timeout: bits %h of register %h never came up", mask, addr);
      aborted = 1'b1;
    end
  endtask

  task automatic wait_ticks(input int count);
    int n;
    for (int i = 0; i < count && !aborted; i++) begin
      n = 0;
      do begin
        @(negedge clk_adc_125mhz);
        n++;
      end while (!u_dut.tick && n < tick_limit);
      if (!u_dut.tick) begin
        $display("timeout: no sample tick within %0d cycles", tick_limit);
        aborted = 1'b1;
      end else begin
        @(negedge clk_adc_125mhz);  // pop, push and flags settle
      end
    end
  endtask

  task automatic wait_irq(input logic [31:0] which, input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk_adc_125mhz);
      n++;
    end while (((which == 0) ? irq_play : irq_rec) !== level && n < irq_limit);
    if (((which == 0) ? irq_play : irq_rec) !== level) begin
      $display("timeout: interrupt %0d did not reach level %b", which, level);
      aborted = 1'b1;
    end
  endtask

  // ----------------------------------------
  task automatic run_vector(input logic [31:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp_val);
    stereo_t     pair;
    logic [31:0] rdata;
    case (op)
      32'h1: u_checker.start_test(data);
      32'h2: write_reg(addr, data);
      32'h3: begin
        if (addr[19:0] == rec_fifo) begin
          check_rec_half();  // record data is random
        end else begin
          read_reg(addr, rdata);
          if (!aborted) u_checker.compare_read(addr, data, exp_val);
        end
      end
      32'h4: poll_reg(addr, data);
      32'h5: for (int i = 0; i < data && !aborted; i++) begin
        pair = stereo_t'($random(seed));
        write_reg(play_fifo, {16'h0, pair.left});   // left goes first
        write_reg(play_fifo, {16'h0, pair.right});
      end
      32'h6: for (int i = 0; i < data && !aborted; i++) begin
        wait_ticks(1);
        if (!aborted) u_checker.compare_line_out(last_out);
      end
      32'h7: for (int i = 0; i < data && !aborted; i++) begin
        @(posedge clk_adc_125mhz);
        #1;
        line_in = stereo_t'($random(seed));  // sampled on the next tick
        wait_ticks(1);
      end
      32'h8: for (int i = 0; i < 2 * data && !aborted; i++) begin
        check_rec_half();
      end
      32'h9: wait_ticks(data);
      32'hA: wait_irq(addr, data[0]);
      32'hB: u_checker.compare_irq(addr, data[0]);
      default: begin
        $display("vector file holds unknown op %h, run stopped", op);
        aborted = 1'b1;
      end
    endcase
  endtask

  initial begin
    seed       = 32'h22530267;
    sys_req    = '0;
    line_in    = '0;
    adc_rstn_i = 1'b0;
    aborted    = 1'b0;
    last_out   = '0;
    play_left  = '0;
    play_half  = 1'b0;
    rec_half   = 1'b0;
    $readmemh("tests/ac97_vectors.txt", vec);
    repeat (2) @(posedge clk_adc_125mhz);
    #1;
    adc_rstn_i = 1'b1;
    idx = 0;
    while (!aborted && idx + 3 < 256 && vec[idx] !== 32'h0 && !$isunknown(vec[idx])) begin
      run_vector(vec[idx], vec[idx+1], vec[idx+2], vec[idx+3]);
      idx += 4;
    end
    u_checker.report();
    if (!aborted && u_checker.errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/ac97_checker.sv
/*
  compares DUT responses against values handed over by the testbench
  read checks use the rdata held with the last ack
  counts checks and errors per test and over the run
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_checker (
  input logic                    clk_adc_125mhz,
  input ac97_bus_pkg::bus_rsp_t  rsp_i,
  input ac97_audio_pkg::stereo_t line_out_i,
  input logic                    irq_play_i,
  input logic                    irq_rec_i
);

  import ac97_bus_pkg::*;
  import ac97_audio_pkg::*;

  int tests       = 0;
  int checks      = 0;
  int errors      = 0;
  int test_id     = 0;
  int test_checks = 0;
  int test_errors = 0;
  bit test_open   = 1'b0;

  task automatic flag_error(input string msg);
    $display("CHECK FAILED time %0d ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  // err is tied low in the bus block
  always @(negedge clk_adc_125mhz) begin
    if (rsp_i.err !== 1'b0) flag_error("bus error output is not low");
  end

  // ----------------------------------------
  task automatic close_test();
    if (test_open) begin
      $display("test %0d %s: %0d checks, %0d errors", test_id,
               (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    end
    test_open = 1'b0;
  endtask

  task automatic start_test(input int id);
    close_test();
    test_id     = id;
    test_checks = 0;
    test_errors = 0;
    test_open   = 1'b1;
    tests++;
  endtask

  task automatic compare_read(input logic [31:0] addr, input logic [31:0] mask,
                              input logic [31:0] exp_val);
    checks++;
    test_checks++;
    if ((rsp_i.rdata & mask) !== exp_val) begin
      flag_error($sformatf("read of %h gave %h under mask %h, expected %h",
                           addr, rsp_i.rdata & mask, mask, exp_val));
    end
  endtask

  task automatic compare_line_out(input stereo_t exp_val);
    checks++;
    test_checks++;
    if (line_out_i !== exp_val) begin
      flag_error($sformatf("line out is %h, expected %h", line_out_i, exp_val));
    end
  endtask

  task automatic compare_irq(input logic [31:0] which, input logic level);
    logic seen;
    seen = (which == 0) ? irq_play_i : irq_rec_i;  // 0 play, 1 record
    checks++;
    test_checks++;
    if (seen !== level) begin
      flag_error($sformatf("interrupt %0d is %b, expected %b", which, seen, level));
    end
  endtask

  task automatic report();
    close_test();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
  endtask

endmodule

`default_nettype wire

//--- source/ac97_ctrl_top.sv
/*
  AC97 controller top, everything runs on the 125 MHz ADC clock
  line_out_o is the play FIFO's held output, it changes only on ticks
  the record FIFO shows its head so reads need no extra latency
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_ctrl_top #(
  parameter int                         fifo_depth     = 16,
  parameter int                         tick_div       = 2604,
  parameter int                         tick_frac      = 5,
  parameter ac97_audio_pkg::irq_level_e play_irq_level = ac97_audio_pkg::irq_half_empty,
  parameter ac97_audio_pkg::irq_level_e rec_irq_level  = ac97_audio_pkg::irq_half_full
) (
  input  logic                    clk_adc_125mhz,
  input  logic                    adc_rstn_i,
  input  ac97_bus_pkg::bus_req_t  sys_req_i,
  output ac97_bus_pkg::bus_rsp_t  sys_rsp_o,
  input  ac97_audio_pkg::stereo_t line_in_i,
  output ac97_audio_pkg::stereo_t line_out_o,
  output logic                    irq_play_o,
  output logic                    irq_rec_o
);

  import ac97_audio_pkg::*;

  localparam int cw = $clog2(fifo_depth + 1);

  logic          tick;  // 48 kHz strobe
  logic          play_push;
  logic          play_flush;
  logic          rec_pop;
  logic          rec_flush;
  stereo_t       play_data;
  stereo_t       rec_data;
  logic [cw-1:0] play_count;
  logic [cw-1:0] rec_count;
  fifo_flags_t   play_flags;
  fifo_flags_t   rec_flags;
  logic          play_underrun;
  logic          rec_overrun;
  codec_cmd_t    codec_cmd;
  sample_t       codec_rdata;
  logic          access_done;

  ac97_sample_tick #(.tick_div(tick_div), .tick_frac(tick_frac)) u_sample_tick (
    .clk_adc_125mhz, .adc_rstn_i, .tick_o(tick)
  );

  ac97_sample_fifo #(.fifo_depth(fifo_depth), .hold_output(1'b1)) u_play_fifo (
    .clk_adc_125mhz, .adc_rstn_i, .flush_i(play_flush),
    .push_i(play_push), .data_i(play_data),
    .pop_i(tick), .data_o(line_out_o), .count_o(play_count)  // drained by the tick
  );

  ac97_sample_fifo #(.fifo_depth(fifo_depth), .hold_output(1'b0)) u_rec_fifo (
    .clk_adc_125mhz, .adc_rstn_i, .flush_i(rec_flush),
    .push_i(tick), .data_i(line_in_i),                       // filled by the tick
    .pop_i(rec_pop), .data_o(rec_data), .count_o(rec_count)
  );

  ac97_fifo_monitor #(
    .fifo_depth(fifo_depth), .play_irq_level(play_irq_level), .rec_irq_level(rec_irq_level)
  ) u_fifo_monitor (
    .clk_adc_125mhz, .adc_rstn_i, .tick_i(tick),
    .play_count_i(play_count), .rec_count_i(rec_count),
    .play_flush_i(play_flush), .rec_flush_i(rec_flush),
    .play_flags_o(play_flags), .rec_flags_o(rec_flags),
    .play_underrun_o(play_underrun), .rec_overrun_o(rec_overrun),
    .irq_play_o, .irq_rec_o
  );

  ac97_codec_regs u_codec_regs (
    .clk_adc_125mhz, .adc_rstn_i, .cmd_i(codec_cmd),
    .rdata_o(codec_rdata), .access_done_o(access_done)
  );

  ac97_bus_regs u_bus_regs (
    .clk_adc_125mhz, .adc_rstn_i, .req_i(sys_req_i), .rsp_o(sys_rsp_o),
    .play_push_o(play_push), .play_data_o(play_data),
    .rec_pop_o(rec_pop), .rec_data_i(rec_data),
    .play_flush_o(play_flush), .rec_flush_o(rec_flush),
    .play_flags_i(play_flags), .rec_flags_i(rec_flags),
    .play_underrun_i(play_underrun), .rec_overrun_i(rec_overrun),
    .codec_cmd_o(codec_cmd), .codec_rdata_i(codec_rdata), .access_done_i(access_done)
  );

endmodule

`default_nettype wire

//--- source/ac97_bus_regs.sv
/*
  register bus decode, play pair assembly and record pair split
  play pushes the cycle after the right half, record pops on the right half
  owns the post reset delay which flushes both FIFOs before codec ready
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_bus_regs (
  input  logic                        clk_adc_125mhz,
  input  logic                        adc_rstn_i,
  input  ac97_bus_pkg::bus_req_t      req_i,
  output ac97_bus_pkg::bus_rsp_t      rsp_o,
  output logic                        play_push_o,
  output ac97_audio_pkg::stereo_t     play_data_o,
  output logic                        rec_pop_o,
  input  ac97_audio_pkg::stereo_t     rec_data_i,
  output logic                        play_flush_o,
  output logic                        rec_flush_o,
  input  ac97_audio_pkg::fifo_flags_t play_flags_i,
  input  ac97_audio_pkg::fifo_flags_t rec_flags_i,
  input  logic                        play_underrun_i,
  input  logic                        rec_overrun_i,
  output ac97_audio_pkg::codec_cmd_t  codec_cmd_o,
  input  ac97_audio_pkg::sample_t     codec_rdata_i,
  input  logic                        access_done_i
);

  import ac97_bus_pkg::*;
  import ac97_audio_pkg::*;

  logic [1:0]  delay_ctr;      // post reset wait
  logic        codec_ready_q;
  sample_t     play_left_q;
  sample_t     play_right_q;
  logic        play_is_right;  // next play write is the right half
  logic        rec_is_right;   // next record read is the right half
  logic [5:0]  cmd_addr_q;
  logic [15:0] cmd_wdata_q;
  logic        cmd_store_q;
  logic        cmd_recall_q;
  logic [31:0] rdata_q;
  logic        ack_q;
  logic [31:0] rd_mux;
  logic [7:0]  status_w;
  logic        play_wr;
  logic        rec_rd;
  logic        flush_wr;
  logic        caddr_wr;
  logic        cwdata_wr;

  assign play_wr   = req_i.wen && (req_i.addr[19:0] == play_fifo);
  assign rec_rd    = req_i.ren && (req_i.addr[19:0] == rec_fifo);
  assign flush_wr  = req_i.wen && (req_i.addr[19:0] == fifo_reset);
  assign caddr_wr  = req_i.wen && (req_i.addr[19:0] == codec_addr);
  assign cwdata_wr = req_i.wen && (req_i.addr[19:0] == codec_wdata);

  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      delay_ctr     <= 2'd3;  // four cycles
      codec_ready_q <= 1'b0;
    end else if (!codec_ready_q) begin
      if (delay_ctr == '0) codec_ready_q <= 1'b1;
      else delay_ctr <= delay_ctr - 1'b1;
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (play_wr && !play_is_right) play_left_q <= req_i.wdata[15:0];
    if (play_wr && play_is_right) play_right_q <= req_i.wdata[15:0];
    if (caddr_wr) cmd_addr_q <= req_i.wdata[6:1];
    if (cwdata_wr) cmd_wdata_q <= req_i.wdata[15:0];
  end

  // ----------------------------------------
  always_comb begin
    status_w                      = '0;
    status_w[stat_play_full]      = play_flags_i.full;
    status_w[stat_play_half_full] = play_flags_i.half_full;
    status_w[stat_rec_full]       = rec_flags_i.full;
    status_w[stat_rec_empty]      = rec_flags_i.empty;
    status_w[stat_access_done]    = access_done_i;
    status_w[stat_codec_ready]    = codec_ready_q;
    status_w[stat_play_underrun]  = play_underrun_i;
    status_w[stat_rec_overrun]    = rec_overrun_i;

    case (req_i.addr[19:0])
      rec_fifo:    rd_mux = {16'h0, rec_is_right ? rec_data_i.right : rec_data_i.left};
      status:      rd_mux = {24'h0, status_w};
      codec_rdata: rd_mux = {16'h0, codec_rdata_i};
      default:     rd_mux = '0;  // write only and unmapped
    endcase
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_is_right <= 1'b0;
      rec_is_right  <= 1'b0;
      play_push_o   <= 1'b0;
      rec_pop_o     <= 1'b0;
      play_flush_o  <= 1'b0;
      rec_flush_o   <= 1'b0;
      cmd_store_q   <= 1'b0;
      cmd_recall_q  <= 1'b0;
      ack_q         <= 1'b0;
      rdata_q       <= '0;
    end else begin
      ack_q        <= req_i.wen | req_i.ren;
      play_push_o  <= play_wr && play_is_right;  // pair complete
      rec_pop_o    <= rec_rd && rec_is_right;    // pair consumed
      play_flush_o <= !codec_ready_q || (flush_wr && req_i.wdata[0]);
      rec_flush_o  <= !codec_ready_q || (flush_wr && req_i.wdata[1]);
      cmd_store_q  <= caddr_wr && !req_i.wdata[7];
      cmd_recall_q <= caddr_wr && req_i.wdata[7];

      if (play_flush_o) play_is_right <= 1'b0;
      else if (play_wr) play_is_right <= !play_is_right;

      if (rec_flush_o) rec_is_right <= 1'b0;
      else if (rec_rd) rec_is_right <= !rec_is_right;

      if (req_i.ren) rdata_q <= rd_mux;
    end
  end

  assign play_data_o = '{right: play_right_q, left: play_left_q};
  assign codec_cmd_o = '{addr: cmd_addr_q, wdata: cmd_wdata_q,
                         store: cmd_store_q, recall: cmd_recall_q};
  assign rsp_o       = '{rdata: rdata_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

//--- source/ac97_codec_regs.sv
/*
  64 word codec register file behind store/recall pulses
  recall data lands in rdata_o two cycles after the recall pulse
  the status word always reads back with the ready bits set
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_codec_regs (
  input  logic                       clk_adc_125mhz,
  input  logic                       adc_rstn_i,
  input  ac97_audio_pkg::codec_cmd_t cmd_i,
  output ac97_audio_pkg::sample_t    rdata_o,
  output logic                       access_done_o
);

  import ac97_audio_pkg::*;

  logic [15:0] mem [64];
  logic [15:0] mem_q;         // first recall stage
  logic        status_hit_q;  // recalled word is the status word
  logic        recall_q;

  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (cmd_i.store) mem[cmd_i.addr] <= cmd_i.wdata;
    if (cmd_i.recall) begin
      mem_q        <= mem[cmd_i.addr];
      status_hit_q <= (cmd_i.addr == codec_status_word);
    end
  end

  // ----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      recall_q      <= 1'b0;
      rdata_o       <= '0;
      access_done_o <= 1'b0;
    end else begin
      recall_q <= cmd_i.recall;
      if (recall_q) rdata_o <= status_hit_q ? (mem_q | codec_ready_mask) : mem_q;

      if (cmd_i.recall) access_done_o <= 1'b0;                     // new read pending
      else if (recall_q || cmd_i.store) access_done_o <= 1'b1;     // write is immediate
    end
  end

endmodule

`default_nettype wire

//--- source/ac97_fifo_monitor.sv
/*
  level flags, sticky underrun/overrun and interrupt lines
  interrupts follow their selected level one cycle late, they do not latch
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_fifo_monitor #(
  parameter int                         fifo_depth     = 16,
  parameter ac97_audio_pkg::irq_level_e play_irq_level = ac97_audio_pkg::irq_half_empty,
  parameter ac97_audio_pkg::irq_level_e rec_irq_level  = ac97_audio_pkg::irq_half_full
) (
  input  logic                            clk_adc_125mhz,
  input  logic                            adc_rstn_i,
  input  logic                            tick_i,
  input  logic [$clog2(fifo_depth+1)-1:0] play_count_i,
  input  logic [$clog2(fifo_depth+1)-1:0] rec_count_i,
  input  logic                            play_flush_i,
  input  logic                            rec_flush_i,
  output ac97_audio_pkg::fifo_flags_t     play_flags_o,
  output ac97_audio_pkg::fifo_flags_t     rec_flags_o,
  output logic                            play_underrun_o,
  output logic                            rec_overrun_o,
  output logic                            irq_play_o,
  output logic                            irq_rec_o
);

  import ac97_audio_pkg::*;

  localparam int cw = $clog2(fifo_depth + 1);

  function automatic fifo_flags_t level_flags(input logic [cw-1:0] count);
    fifo_flags_t f;
    f.empty      = (count == '0);
    f.half_empty = (count <  cw'(fifo_depth / 2));
    f.half_full  = (count >= cw'(fifo_depth / 2));
    f.full       = (count >= cw'(fifo_depth - 1));  // one slot early, as the codec IP
    return f;
  endfunction

  function automatic logic irq_cond(input irq_level_e lvl, input fifo_flags_t f);
    case (lvl)
      irq_empty:      return f.empty;
      irq_half_empty: return f.half_empty;
      irq_half_full:  return f.half_full;
      irq_full:       return f.full;
      default:        return 1'b0;  // irq_none
    endcase
  endfunction

  assign play_flags_o = level_flags(play_count_i);
  assign rec_flags_o  = level_flags(rec_count_i);

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      irq_play_o      <= 1'b0;
      irq_rec_o       <= 1'b0;
      play_underrun_o <= 1'b0;
      rec_overrun_o   <= 1'b0;
    end else begin
      irq_play_o <= irq_cond(play_irq_level, play_flags_o);
      irq_rec_o  <= irq_cond(rec_irq_level, rec_flags_o);

      if (play_flush_i) play_underrun_o <= 1'b0;
      else if (tick_i && play_flags_o.empty) play_underrun_o <= 1'b1;  // nothing to play

      if (rec_flush_i) rec_overrun_o <= 1'b0;
      else if (tick_i && rec_flags_o.full) rec_overrun_o <= 1'b1;      // no room left
    end
  end

endmodule

`default_nettype wire

//--- source/ac97_sample_fifo.sv
/*
  synchronous stereo FIFO, fifo_depth must be a power of two
  push when full and pop when empty are dropped
  hold_output=1 gives the last popped pair, 0 shows the head entry
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_sample_fifo #(
  parameter int fifo_depth  = 16,
  parameter bit hold_output = 1'b1
) (
  input  logic                            clk_adc_125mhz,
  input  logic                            adc_rstn_i,
  input  logic                            flush_i,
  input  logic                            push_i,
  input  ac97_audio_pkg::stereo_t         data_i,
  input  logic                            pop_i,
  output ac97_audio_pkg::stereo_t         data_o,
  output logic [$clog2(fifo_depth+1)-1:0] count_o
);

  import ac97_audio_pkg::*;

  localparam int pw = $clog2(fifo_depth);
  localparam int cw = $clog2(fifo_depth + 1);

  stereo_t       mem [fifo_depth];
  stereo_t       head;    // oldest entry
  stereo_t       pop_q;   // last popped pair
  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic          push_ok;
  logic          pop_ok;

  assign push_ok = push_i && (count_o < cw'(fifo_depth));
  assign pop_ok  = pop_i && (count_o != '0);
  assign head    = mem[rd_ptr];
  assign data_o  = hold_output ? pop_q : head;

  always_ff @(posedge clk_adc_125mhz) begin
    if (push_ok) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
      pop_q   <= '0;
    end else if (flush_i) begin
      wr_ptr  <= '0;  // drop all entries, output holds
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
        pop_q  <= head;
      end
      count_o <= count_o + cw'(push_ok) - cw'(pop_ok);
    end
  end

endmodule

`default_nettype wire

//--- source/ac97_sample_tick.sv
/*
  48 kHz sample strobe from the 125 MHz ADC clock
  tick_frac short runs of tick_div cycles, then one run of tick_div+1
  tick_frac must be at least 1
*/
`timescale 1ns/1ps
`default_nettype none

module ac97_sample_tick #(
  parameter int tick_div  = 2604,  // short run length
  parameter int tick_frac = 5      // short runs per long run
) (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  output logic tick_o
);

  localparam int cw = $clog2(tick_div + 1);
  localparam int fw = $clog2(tick_frac + 1);

  logic [cw-1:0] period_ctr;  // position in current run
  logic [fw-1:0] run_ctr;     // runs since last long one
  logic [cw-1:0] run_last;    // last count of this run

  assign run_last = (run_ctr == fw'(tick_frac)) ? cw'(tick_div) : cw'(tick_div - 1);

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      period_ctr <= '0;
      run_ctr    <= '0;
      tick_o     <= 1'b0;
    end else if (period_ctr == run_last) begin
      period_ctr <= '0;
      run_ctr    <= (run_ctr == fw'(tick_frac)) ? '0 : run_ctr + 1'b1;
      tick_o     <= 1'b1;  // one cycle strobe
    end else begin
      period_ctr <= period_ctr + 1'b1;
      tick_o     <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/ac97_audio_pkg.sv
/*
  audio side types of the AC97 controller
  a stereo pair keeps right in the upper half, left in the lower half
*/
`default_nettype none

package ac97_audio_pkg;

  typedef logic signed [15:0] sample_t;

  typedef struct packed {
    sample_t right;
    sample_t left;
  } stereo_t;

  typedef struct packed {
    logic empty;       // count is zero
    logic half_empty;  // below depth/2
    logic half_full;   // depth/2 or more
    logic full;        // depth-1 or more
  } fifo_flags_t;

  typedef struct packed {
    logic [5:0]  addr;    // codec word address
    logic [15:0] wdata;
    logic        store;   // write pulse
    logic        recall;  // read pulse
  } codec_cmd_t;

  typedef enum logic [2:0] {
    irq_none,
    irq_empty,
    irq_half_empty,
    irq_half_full,
    irq_full
  } irq_level_e;

  localparam logic [5:0]  codec_status_word = 6'h13;     // powerdown/status word
  localparam logic [15:0] codec_ready_mask  = 16'h000F;  // sections always ready

endpackage

`default_nettype wire

//--- source/ac97_bus_pkg.sv
/*
  register bus types for the AC97 controller
  only addr[19:0] is decoded, upper address bits are ignored
  one strobe per cycle, read and write are never asserted together
*/
`default_nettype none

package ac97_bus_pkg;

  typedef struct packed {
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;
    logic        wen;    // single cycle write strobe
    logic        ren;    // single cycle read strobe
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // valid together with ack
    logic        ack;
    logic        err;    // never raised
  } bus_rsp_t;

  typedef enum logic [19:0] {
    play_fifo   = 20'h00000,  // wo, left then right
    rec_fifo    = 20'h00004,  // ro, left then right
    status      = 20'h00008,
    fifo_reset  = 20'h0000C,  // bit0 play, bit1 record
    codec_addr  = 20'h00010,  // bits 6:1 word, bit 7 read
    codec_rdata = 20'h00014,
    codec_wdata = 20'h00018
  } reg_addr_e;

  // status word layout
  typedef enum logic [2:0] {
    stat_play_full      = 3'd0,
    stat_play_half_full = 3'd1,
    stat_rec_full       = 3'd2,
    stat_rec_empty      = 3'd3,
    stat_access_done    = 3'd4,
    stat_codec_ready    = 3'd5,
    stat_play_underrun  = 3'd6,
    stat_rec_overrun    = 3'd7
  } status_bit_e;

endpackage

`default_nettype wire
